//--- verilog/i2s_consts.svh
// ********************
// build-time constants for the i2s transmitter
// sample width and fifo depth are fixed here, fifo depth must be a power of two
// register addresses are 32-bit aligned byte offsets
// ********************
`ifndef I2S_CONSTS_SVH
`define I2S_CONSTS_SVH

// bits per channel word, one stereo frame is twice this
`define SAMPLE_BITS 16

// frames held in the sample fifo
`define FIFO_DEPTH 8

// level counts 0 to FIFO_DEPTH, so one bit wider than the pointers
`define FIFO_LVL_BITS 4

// axi-lite register map
// DATA is write-only, STATUS is read-only
`define ADDR_DATA 32'h0000_0000
`define ADDR_CTRL 32'h0000_0004
`define ADDR_STATUS 32'h0000_0008

`endif

//--- verilog/axil_pkg.sv
// ********************
// axi4-lite channel types, 32-bit address and data
// no prot and no strobes, ready flags travel as separate wires
// ********************
`default_nettype none

package axil_pkg;

  // only the two codes this slave ever returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_t;

  // write address, master to slave
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } axil_aw_t;

  // write data, master to slave
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } axil_w_t;

  // write response, slave to master
  typedef struct packed {
    logic       valid;
    axil_resp_t resp;
  } axil_b_t;

  // read address, master to slave
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } axil_ar_t;

  // read data, slave to master
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    axil_resp_t  resp;
  } axil_r_t;

endpackage

`default_nettype wire

//--- verilog/i2s_pkg.sv
// ********************
// audio-side types for the i2s transmitter
// frame and control word are both one 32-bit bus word
// ********************
`default_nettype none

`include "i2s_consts.svh"

package i2s_pkg;

  // stereo frame, left channel in the upper half
  typedef struct packed {
    logic [`SAMPLE_BITS-1:0] left;
    logic [`SAMPLE_BITS-1:0] right;
  } i2s_frame_t;

  // CTRL register layout
  typedef struct packed {
    logic [29:0] rsvd;
    // write 1 to drop the sticky underrun flag
    logic        clr_underrun;
    // 0 mutes output and holds the fifo
    logic        enable;
  } i2s_ctrl_t;

  // one write-data word, read as a frame for DATA
  // and as a control word for CTRL
  typedef union packed {
    i2s_frame_t frame;
    i2s_ctrl_t  ctrl;
  } i2s_wdata_u;

endpackage

`default_nettype wire

//--- verilog/flex_counter.sv
// ********************
// up counter, 1 to rollover_val then back to 1
// clear forces 0 and wins over count_enable
// ********************
`timescale 1ns/1ps
`default_nettype none

module flex_counter #(
  parameter int NUM_CNT_BITS = 4
) (
  input  wire                     clk,
  input  wire                     n_rst,
  input  wire                     clear,
  input  wire                     count_enable,
  input  wire  [NUM_CNT_BITS-1:0] rollover_val,
  output logic [NUM_CNT_BITS-1:0] count_out,
  output logic                    rollover_flag
);

  logic [NUM_CNT_BITS-1:0] next_count;

  always_comb begin
    next_count = count_out;
    if (clear) begin
      next_count = '0;
    end else if (count_enable) begin
      // wrap skips 0, it only comes back through clear or reset
      if (count_out == rollover_val) begin
        next_count = NUM_CNT_BITS'(1);
      end else begin
        next_count = count_out + 1'b1;
      end
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      count_out     <= '0;
      rollover_flag <= 1'b0;
    end else begin
      count_out     <= next_count;
      // flag registered alongside the count it describes
      rollover_flag <= (next_count == rollover_val);
    end
  end

  a_count_in_range: assert property (@(posedge clk) disable iff (!n_rst)
    count_out <= rollover_val);

endmodule

`default_nettype wire

//--- verilog/i2s_trnmtr_cntlr.sv
// ********************
// word-select and start generator, free running from reset
// one half-frame is SAMPLE_BITS clk cycles, ws low is left
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "i2s_consts.svh"

module i2s_trnmtr_cntlr (
  input  wire  clk,
  input  wire  n_rst,
  output logic ws,
  output logic start
);

  // one extra bit so the count can reach SAMPLE_BITS itself
  localparam int CNT_BITS = $clog2(`SAMPLE_BITS) + 1;

  logic [CNT_BITS-1:0] edge_count;
  logic                half_done;

  // edge counter, never cleared
  flex_counter #(
    .NUM_CNT_BITS(CNT_BITS)
  ) i_edge_counter (
    .clk          (clk),
    .n_rst        (n_rst),
    .clear        (1'b0),
    .count_enable (1'b1),
    .rollover_val (CNT_BITS'(`SAMPLE_BITS)),
    .count_out    (edge_count),
    .rollover_flag(half_done)
  );

  // flip ws on the edge where the count wraps to 1
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      ws <= 1'b0;
    end else if (half_done) begin
      ws <= !ws;
    end
  end

  // first cycle of each half-frame, ws already shows the new side
  assign start = (edge_count == CNT_BITS'(1));

  a_ws_on_rollover: assert property (@(posedge clk) disable iff (!n_rst)
    $changed(ws) |-> $past(half_done));

endmodule

`default_nettype wire

//--- verilog/i2s_sample_fifo.sv
// ********************
// frame fifo, head is visible one cycle after the push
// caller must not push when full or pop when empty
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "i2s_consts.svh"

module i2s_sample_fifo (
  input  wire                       clk,
  input  wire                       n_rst,
  input  wire                       push,
  input  wire i2s_pkg::i2s_frame_t  push_frame,
  input  wire                       pop,
  output i2s_pkg::i2s_frame_t       head,
  output logic                      empty,
  output logic                      full,
  output logic [`FIFO_LVL_BITS-1:0] level
);

  import i2s_pkg::*;

  localparam int PTR_BITS = $clog2(`FIFO_DEPTH);

  i2s_frame_t                mem [`FIFO_DEPTH];
  logic [PTR_BITS-1:0]       wr_ptr;
  logic [PTR_BITS-1:0]       rd_ptr;
  logic [`FIFO_LVL_BITS-1:0] count;

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_frame;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == `FIFO_LVL_BITS'(`FIFO_DEPTH));
  assign level = count;

  a_no_push_full: assert property (@(posedge clk) disable iff (!n_rst)
    push |-> !full);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!n_rst)
    pop |-> !empty);

endmodule

`default_nettype wire

//--- verilog/i2s_shift_reg.sv
// ********************
// msb-first serializer, one bit per clk
// frames are taken from the fifo only at the start of a left half
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "i2s_consts.svh"

module i2s_shift_reg (
  input  wire                      clk,
  input  wire                      n_rst,
  input  wire                      ws,
  input  wire                      start,
  input  wire                      enable,
  input  wire                      clear_underrun,
  input  wire i2s_pkg::i2s_frame_t head,
  input  wire                      empty,
  output logic                     pop,
  output logic                     underrun,
  output logic                     sd
);

  import i2s_pkg::*;

  logic                    load_left;
  i2s_frame_t              frame_next;
  logic [`SAMPLE_BITS-1:0] right_q;
  logic [`SAMPLE_BITS-1:0] shreg;

  assign load_left = start && !ws;
  assign pop       = load_left && enable && !empty;
  // muted or starved frames go out as silence
  assign frame_next = pop ? head : '0;

  // right half waits here until ws goes high
  always_ff @(posedge clk) begin
    if (load_left) begin
      right_q <= frame_next.right;
    end
  end

  // load on start, shift left otherwise
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      shreg <= '0;
    end else if (start) begin
      shreg <= ws ? right_q : frame_next.left;
    end else begin
      shreg <= {shreg[`SAMPLE_BITS-2:0], 1'b0};
    end
  end

  // sticky, a new underrun beats a clear in the same cycle
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      underrun <= 1'b0;
    end else if (load_left && enable && empty) begin
      underrun <= 1'b1;
    end else if (clear_underrun) begin
      underrun <= 1'b0;
    end
  end

  // register output gives the one-bit delay after ws
  assign sd = shreg[`SAMPLE_BITS-1];

  a_pop_not_empty: assert property (@(posedge clk) disable iff (!n_rst)
    pop |-> !empty);

endmodule

`default_nettype wire

//--- verilog/i2s_axil_regs.sv
// ********************
// axi4-lite slave, DATA (wo), CTRL (rw), STATUS (ro)
// one outstanding response per direction, strobes not supported
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "i2s_consts.svh"

module i2s_axil_regs (
  input  wire                       clk,
  input  wire                       n_rst,
  input  wire axil_pkg::axil_aw_t   aw,
  input  wire axil_pkg::axil_w_t    w,
  input  wire axil_pkg::axil_ar_t   ar,
  input  wire                       bready,
  input  wire                       rready,
  output logic                      awready,
  output logic                      wready,
  output logic                      arready,
  output axil_pkg::axil_b_t         b,
  output axil_pkg::axil_r_t         r,
  output logic                      push,
  output i2s_pkg::i2s_frame_t       push_frame,
  output logic                      enable,
  output logic                      clear_underrun,
  input  wire [`FIFO_LVL_BITS-1:0]  level,
  input  wire                       full,
  input  wire                       underrun
);

  import axil_pkg::*;
  import i2s_pkg::*;

  logic        wr_accept;
  logic        rd_accept;
  i2s_wdata_u  wdata;
  axil_resp_t  wr_resp;
  axil_resp_t  rd_resp;
  logic [31:0] rd_data;

  // aw and w must arrive together, nothing taken while a response waits
  assign wr_accept = aw.valid && w.valid && !b.valid;
  assign rd_accept = ar.valid && !r.valid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign arready   = rd_accept;

  assign wdata      = w.data;
  assign push_frame = wdata.frame;

  // write decode
  always_comb begin
    push    = 1'b0;
    wr_resp = OKAY;
    case (aw.addr)
      `ADDR_DATA: begin
        // full fifo drops the frame
        if (full) begin
          wr_resp = SLVERR;
        end else begin
          push = wr_accept;
        end
      end
      `ADDR_CTRL: wr_resp = OKAY;
      // STATUS is read-only
      default: wr_resp = SLVERR;
    endcase
  end

  // read decode
  always_comb begin
    rd_data = '0;
    rd_resp = OKAY;
    case (ar.addr)
      `ADDR_DATA:   rd_data = '0;
      `ADDR_CTRL:   rd_data[0] = enable;
      `ADDR_STATUS: rd_data = {{(30 - `FIFO_LVL_BITS){1'b0}}, underrun, full, level};
      default:      rd_resp = SLVERR;
    endcase
  end

  // control bits, clear_underrun is a one-cycle pulse
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      enable         <= 1'b0;
      clear_underrun <= 1'b0;
    end else begin
      clear_underrun <= 1'b0;
      if (wr_accept && (aw.addr == `ADDR_CTRL)) begin
        enable         <= wdata.ctrl.enable;
        clear_underrun <= wdata.ctrl.clr_underrun;
      end
    end
  end

  // write response, held until bready
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      b <= '0;
    end else if (wr_accept) begin
      b.valid <= 1'b1;
      b.resp  <= wr_resp;
    end else if (bready) begin
      b.valid <= 1'b0;
    end
  end

  // read response, held until rready
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      r <= '0;
    end else if (rd_accept) begin
      r.valid <= 1'b1;
      r.data  <= rd_data;
      r.resp  <= rd_resp;
    end else if (rready) begin
      r.valid <= 1'b0;
    end
  end

  a_b_stable: assert property (@(posedge clk) disable iff (!n_rst)
    b.valid && !bready |=> $stable(b));
  a_r_stable: assert property (@(posedge clk) disable iff (!n_rst)
    r.valid && !rready |=> $stable(r));

endmodule

`default_nettype wire

//--- verilog/i2s_trnmtr.sv
// ********************
// i2s transmitter top, axi4-lite in, ws and sd out
// bit clock is clk itself and is not brought out
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "i2s_consts.svh"

module i2s_trnmtr (
  input  wire                     clk,
  input  wire                     n_rst,
  input  wire axil_pkg::axil_aw_t aw,
  input  wire axil_pkg::axil_w_t  w,
  input  wire axil_pkg::axil_ar_t ar,
  input  wire                     bready,
  input  wire                     rready,
  output logic                    awready,
  output logic                    wready,
  output logic                    arready,
  output axil_pkg::axil_b_t       b,
  output axil_pkg::axil_r_t       r,
  output logic                    ws,
  output logic                    sd
);

  import i2s_pkg::*;

  // bus side to fifo and shifter
  logic                      push;
  i2s_frame_t                push_frame;
  logic                      enable;
  logic                      clear_underrun;
  // status back to the bus side
  logic [`FIFO_LVL_BITS-1:0] level;
  logic                      full;
  logic                      underrun;
  // fifo to shifter
  i2s_frame_t                head;
  logic                      empty;
  logic                      pop;
  logic                      start;

  i2s_axil_regs i_axil_regs (
    .clk(clk), .n_rst(n_rst),
    .aw(aw), .w(w), .ar(ar), .bready(bready), .rready(rready),
    .awready(awready), .wready(wready), .arready(arready), .b(b), .r(r),
    .push(push), .push_frame(push_frame),
    .enable(enable), .clear_underrun(clear_underrun),
    .level(level), .full(full), .underrun(underrun)
  );

  i2s_sample_fifo i_sample_fifo (
    .clk(clk), .n_rst(n_rst),
    .push(push), .push_frame(push_frame), .pop(pop), .head(head),
    .empty(empty), .full(full), .level(level)
  );

  i2s_trnmtr_cntlr i_trnmtr_cntlr (
    .clk(clk), .n_rst(n_rst), .ws(ws), .start(start)
  );

  i2s_shift_reg i_shift_reg (
    .clk(clk), .n_rst(n_rst), .ws(ws), .start(start),
    .enable(enable), .clear_underrun(clear_underrun),
    .head(head), .empty(empty), .pop(pop), .underrun(underrun), .sd(sd)
  );

endmodule

`default_nettype wire

//--- bench/i2s_monitor.sv
// ********************
// checker for the i2s transmitter that samples on the rising edge
// models fifo, enable, underrun and bus responses from the traffic it sees
// half-frame timing is counted from reset release
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "i2s_consts.svh"

module i2s_monitor (
  input  wire                     clk,
  input  wire                     n_rst,
  input  wire axil_pkg::axil_aw_t aw,
  input  wire axil_pkg::axil_w_t  w,
  input  wire axil_pkg::axil_ar_t ar,
  input  wire                     bready,
  input  wire                     rready,
  input  wire                     awready,
  input  wire                     wready,
  input  wire                     arready,
  input  wire axil_pkg::axil_b_t  b,
  input  wire axil_pkg::axil_r_t  r,
  input  wire                     ws,
  input  wire                     sd,
  output int                      ws_errors,
  output int                      data_errors,
  output int                      bus_errors
);

  import axil_pkg::*;
  import i2s_pkg::*;

  // model state as the dut holds it after the current edge
  i2s_frame_t              fifo_q[$];
  i2s_frame_t              cur_frame;
  logic                    en;
  logic                    und;
  logic                    clr_pend;
  // values the dut sees just before the edge
  int                      pre_size;
  logic                    pre_en;
  logic                    pre_und;
  // serial side
  int                      n;
  logic                    exp_ws;
  logic                    collecting;
  int                      nbits;
  logic [`SAMPLE_BITS-1:0] word;
  logic [`SAMPLE_BITS-1:0] exp_word;
  logic                    word_right;
  // bus side
  axil_resp_t              exp_bresp;
  axil_resp_t              exp_rresp;
  logic [31:0]             exp_rdata;
  logic                    exp_bvalid;
  logic                    exp_rvalid;
  logic                    wr_acc;
  logic                    rd_acc;
  axil_b_t                 b_prev;
  axil_r_t                 r_prev;
  logic                    b_wait;
  logic                    r_wait;
  int                      n_ws_err = 0;
  int                      n_data_err = 0;
  int                      n_bus_err = 0;

  assign ws_errors   = n_ws_err;
  assign data_errors = n_data_err;
  assign bus_errors  = n_bus_err;

  always @(posedge clk) begin
    if (!n_rst) begin
      fifo_q.delete();
      cur_frame  = '0;
      en         = 1'b0;
      und        = 1'b0;
      clr_pend   = 1'b0;
      n          = 0;
      collecting = 1'b0;
      b_wait     = 1'b0;
      r_wait     = 1'b0;
      exp_bvalid = 1'b0;
      exp_rvalid = 1'b0;
    end else begin
      n = n + 1;

      // ws low through the count-0 cycle and first half and toggles every 16 after
      exp_ws = (n < 2) ? 1'b0 : 1'(((n - 2) / `SAMPLE_BITS) % 2);
      if (ws !== exp_ws) begin
        $display("[ERROR] %0t ns ws: got %b expected %b", $time, ws, exp_ws);
        n_ws_err++;
      end

      // msb first with the last bit on the next boundary cycle
      if (collecting) begin
        word  = {word[`SAMPLE_BITS-2:0], sd};
        nbits = nbits + 1;
        if (nbits == `SAMPLE_BITS) begin
          collecting = 1'b0;
          if (word !== exp_word) begin
            $display("[ERROR] %0t ns sd %s word: got %h expected %h", $time,
                     word_right ? "right" : "left", word, exp_word);
            n_data_err++;
          end
        end
      end

      pre_size = fifo_q.size();
      pre_en   = en;
      pre_und  = und;

      // the shifter loads on this boundary edge
      if (n >= 2 && ((n - 2) % `SAMPLE_BITS) == 0) begin
        if (!exp_ws) begin
          // frame taken only when enabled and something is queued
          if (pre_en && pre_size > 0) begin
            cur_frame = fifo_q.pop_front();
          end else begin
            cur_frame = '0;
          end
          exp_word = cur_frame.left;
        end else begin
          exp_word = cur_frame.right;
        end
        word_right = exp_ws;
        collecting = 1'b1;
        nbits      = 0;
        word       = '0;
        // starved left start wins over a pending clear
        if (!exp_ws && pre_en && pre_size == 0) begin
          und = 1'b1;
        end else if (clr_pend) begin
          und = 1'b0;
        end
      end else if (clr_pend) begin
        und = 1'b0;
      end
      clr_pend = 1'b0;

      // handshake rules
      wr_acc = aw.valid && w.valid && !exp_bvalid;
      rd_acc = ar.valid && !exp_rvalid;
      if (awready !== wr_acc) begin
        $display("[ERROR] %0t ns awready: got %b expected %b", $time, awready, wr_acc);
        n_bus_err++;
      end
      if (wready !== wr_acc) begin
        $display("[ERROR] %0t ns wready: got %b expected %b", $time, wready, wr_acc);
        n_bus_err++;
      end
      if (arready !== rd_acc) begin
        $display("[ERROR] %0t ns arready: got %b expected %b", $time, arready, rd_acc);
        n_bus_err++;
      end
      if (b.valid !== exp_bvalid) begin
        $display("[ERROR] %0t ns b.valid: got %b expected %b", $time, b.valid, exp_bvalid);
        n_bus_err++;
      end
      if (r.valid !== exp_rvalid) begin
        $display("[ERROR] %0t ns r.valid: got %b expected %b", $time, r.valid, exp_rvalid);
        n_bus_err++;
      end

      // responses held stable until taken
      if (b_wait && b !== b_prev) begin
        $display("write response changed at %0t ns while bready was low", $time);
        n_bus_err++;
      end
      if (r_wait && r !== r_prev) begin
        $display("read response changed at %0t ns while rready was low", $time);
        n_bus_err++;
      end
      if (exp_bvalid && b.resp !== exp_bresp) begin
        $display("[ERROR] %0t ns b.resp: got %b expected %b", $time, b.resp, exp_bresp);
        n_bus_err++;
      end
      if (exp_rvalid && r.resp !== exp_rresp) begin
        $display("[ERROR] %0t ns r.resp: got %b expected %b", $time, r.resp, exp_rresp);
        n_bus_err++;
      end else if (exp_rvalid && exp_rresp == OKAY && r.data !== exp_rdata) begin
        $display("[ERROR] %0t ns r.data: got %h expected %h", $time, r.data, exp_rdata);
        n_bus_err++;
      end
      b_wait = exp_bvalid && !bready;
      r_wait = exp_rvalid && !rready;
      b_prev = b;
      r_prev = r;

      // a response drops when taken and rises the cycle after an accept
      if (bready) begin
        exp_bvalid = 1'b0;
      end
      if (wr_acc) begin
        exp_bvalid = 1'b1;
      end
      if (rready) begin
        exp_rvalid = 1'b0;
      end
      if (rd_acc) begin
        exp_rvalid = 1'b1;
      end

      // accepted write
      if (wr_acc) begin
        exp_bresp = OKAY;
        if (aw.addr == `ADDR_DATA) begin
          if (pre_size == `FIFO_DEPTH) begin
            exp_bresp = SLVERR;
          end else begin
            fifo_q.push_back(w.data);
          end
        end else if (aw.addr == `ADDR_CTRL) begin
          en       = w.data[0];
          clr_pend = w.data[1];
        end else begin
          exp_bresp = SLVERR;
        end
      end

      // accepted read sees status from the pre-edge model
      if (rd_acc) begin
        exp_rresp = OKAY;
        exp_rdata = '0;
        if (ar.addr == `ADDR_CTRL) begin
          exp_rdata[0] = pre_en;
        end else if (ar.addr == `ADDR_STATUS) begin
          exp_rdata = 32'(pre_size) | (32'(pre_size == `FIFO_DEPTH) << 4)
                      | (32'(pre_und) << 5);
        end else if (ar.addr != `ADDR_DATA) begin
          exp_rresp = SLVERR;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_i2s_trnmtr.sv
// ********************
// axi master drives on the falling edge from an lfsr seeded with 32'h89c2
// comparing and error counts live in i2s_monitor
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "i2s_consts.svh"

module tb_i2s_trnmtr;

  import axil_pkg::*;

  localparam int FRAME_CYCLES = 2 * `SAMPLE_BITS;
  localparam int NUM_TESTS    = 5;
  // 64 frame periods per test plus some slack
  localparam int CYCLE_LIMIT  = NUM_TESTS * 64 * FRAME_CYCLES + 1000;

  logic        clk = 1'b0;
  logic        n_rst;
  axil_aw_t    aw;
  axil_w_t     w;
  axil_ar_t    ar;
  logic        bready;
  logic        rready;
  logic        awready;
  logic        wready;
  logic        arready;
  axil_b_t     b;
  axil_r_t     r;
  logic        ws;
  logic        sd;
  int          ws_errors;
  int          data_errors;
  int          bus_errors;
  int          cycles = 0;
  logic [31:0] lfsr = 32'h89c2;
  logic [31:0] rd_data;
  axil_resp_t  rd_resp;
  int          i;

  i2s_trnmtr i_i2s_trnmtr (
    .clk(clk), .n_rst(n_rst),
    .aw(aw), .w(w), .ar(ar), .bready(bready), .rready(rready),
    .awready(awready), .wready(wready), .arready(arready), .b(b), .r(r),
    .ws(ws), .sd(sd)
  );

  i2s_monitor i_monitor (
    .clk(clk), .n_rst(n_rst),
    .aw(aw), .w(w), .ar(ar), .bready(bready), .rready(rready),
    .awready(awready), .wready(wready), .arready(arready), .b(b), .r(r),
    .ws(ws), .sd(sd),
    .ws_errors(ws_errors), .data_errors(data_errors), .bus_errors(bus_errors)
  );

  always #10 clk = ~clk;

  // hard stop if a handshake or drain never finishes
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing the tests", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
  // one step per bit taken
  function automatic logic rand_bit();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < nbits; k++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  task automatic idle(input int ncyc);
    repeat (ncyc) @(negedge clk);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk);
    aw.valid = 1'b1;
    aw.addr  = addr;
    w.valid  = 1'b1;
    w.data   = data;
    @(posedge clk);
    while (!awready) @(posedge clk);
    @(negedge clk);
    aw.valid = 1'b0;
    w.valid  = 1'b0;
    // bready high about three cycles in four
    bready = rand_bit() | rand_bit();
    @(posedge clk);
    while (!(b.valid && bready)) begin
      @(negedge clk);
      bready = rand_bit() | rand_bit();
      @(posedge clk);
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output axil_resp_t resp);
    @(negedge clk);
    ar.valid = 1'b1;
    ar.addr  = addr;
    @(posedge clk);
    while (!arready) @(posedge clk);
    @(negedge clk);
    ar.valid = 1'b0;
    rready   = rand_bit() | rand_bit();
    @(posedge clk);
    while (!(r.valid && rready)) begin
      @(negedge clk);
      rready = rand_bit() | rand_bit();
      @(posedge clk);
    end
    data = r.data;
    resp = r.resp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // random frames with random gaps of 0 to 3 cycles
  task automatic write_frames(input int count);
    repeat (count) begin
      bus_write(`ADDR_DATA, rand_bits(32));
      idle(rand_bits(2));
    end
  endtask

  // poll level down to zero and let the last frame play out
  task automatic drain_fifo();
    logic [31:0] status;
    axil_resp_t  resp;
    status = '1;
    while (status[3:0] != 4'd0) begin
      idle(8);
      bus_read(`ADDR_STATUS, status, resp);
    end
    idle(2 * FRAME_CYCLES + 4);
  endtask

  initial begin
    n_rst  = 1'b0;
    aw     = '0;
    w      = '0;
    ar     = '0;
    bready = 1'b0;
    rready = 1'b0;
    repeat (3) @(negedge clk);
    n_rst = 1'b1;

    // enabled playback in write order
    bus_write(`ADDR_CTRL, 32'h1);
    write_frames(6);
    drain_fifo();

    // fifo holds its frames while muted
    bus_write(`ADDR_CTRL, 32'h0);
    write_frames(5);
    idle(3 * FRAME_CYCLES);
    bus_read(`ADDR_STATUS, rd_data, rd_resp);
    bus_write(`ADDR_CTRL, 32'h1);
    drain_fifo();

    // starved fifo sets underrun
    idle(2 * FRAME_CYCLES);
    bus_read(`ADDR_STATUS, rd_data, rd_resp);
    // clear it with output off
    bus_write(`ADDR_CTRL, 32'h2);
    idle(4);
    bus_read(`ADDR_STATUS, rd_data, rd_resp);

    // overfill while muted
    // the two extra writes see SLVERR
    write_frames(`FIFO_DEPTH + 2);
    bus_read(`ADDR_STATUS, rd_data, rd_resp);
    bus_read(`ADDR_CTRL, rd_data, rd_resp);
    bus_write(`ADDR_CTRL, 32'h1);
    drain_fifo();

    // unknown addresses
    bus_read(32'h0000_000c, rd_data, rd_resp);
    bus_write(32'h0000_0010, rand_bits(32));
    bus_write(`ADDR_STATUS, rand_bits(32));
    // mixed traffic over the four register slots
    for (i = 0; i < 12; i++) begin
      if (rand_bit()) begin
        write_frames(1);
      end else begin
        bus_read(rand_bits(2) << 2, rd_data, rd_resp);
      end
    end
    drain_fifo();

    $display("closing report: ws errors %0d, sd data errors %0d, bus errors %0d",
             ws_errors, data_errors, bus_errors);
    if (ws_errors + data_errors + bus_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+verilog
verilog/axil_pkg.sv
verilog/i2s_pkg.sv
verilog/flex_counter.sv
verilog/i2s_trnmtr_cntlr.sv
verilog/i2s_sample_fifo.sv
verilog/i2s_shift_reg.sv
verilog/i2s_axil_regs.sv
verilog/i2s_trnmtr.sv
bench/i2s_monitor.sv
bench/tb_i2s_trnmtr.sv
